/* rtl/eeprom_pkg.sv */
package eeprom_pkg;

  // 24c16 style part, 2048 bytes
  typedef logic [10:0] addr_t;
  typedef logic [7:0]  byte_t;

  // quarter-bit phase index from the bit timer
  typedef logic [1:0]  bit_phase_t;

  localparam bit_phase_t ph_low  = 2'd0;  // scl low, sda may change
  localparam bit_phase_t ph_rise = 2'd1;  // scl rising
  localparam bit_phase_t ph_high = 2'd2;  // sample, start/stop edge
  localparam bit_phase_t ph_fall = 2'd3;  // scl falling

  // commands from the main fsm to the serial shifter
  typedef enum logic [2:0] {
    cmd_none,
    cmd_start,
    cmd_stop,
    cmd_send,
    cmd_recv
  } shift_cmd_e;

  // device type code at the head of every control byte
  localparam logic [3:0] ctrl_code = 4'b1010;

endpackage

/* rtl/scl_timer.sv */
module scl_timer import eeprom_pkg::*; #(
  parameter int clk_div = 4
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       run,
  output logic       tick,
  output bit_phase_t phase,
  output logic       scl
);

  localparam int               cnt_w    = (clk_div > 1) ? $clog2(clk_div) : 1;
  localparam logic [cnt_w-1:0] cnt_last = cnt_w'(clk_div - 1);

  logic [cnt_w-1:0] cnt;
  bit_phase_t       phase_nxt;

  // last cycle of each quarter bit
  assign tick = run && (cnt == cnt_last);

  always_comb begin
    phase_nxt = phase;
    if (!run) begin
      phase_nxt = ph_low;
    end else if (tick) begin
      phase_nxt = bit_phase_t'(phase + 2'd1);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt   <= '0;
      phase <= ph_low;
      scl   <= 1'b1;
    end else begin
      if (!run || tick) begin
        cnt <= '0;
      end else begin
        cnt <= cnt + 1'b1;
      end
      phase <= phase_nxt;
      // follows the phase register, idles high
      scl   <= !run || (phase_nxt == ph_rise) || (phase_nxt == ph_high);
    end
  end

endmodule

/* rtl/sda_shifter.sv */
module sda_shifter import eeprom_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  shift_cmd_e cmd,
  input  logic       load,
  input  byte_t      tx_byte,
  input  logic       tick,
  input  bit_phase_t phase,
  input  logic       sda_in,
  output logic       sda_out,
  output logic       sda_en,
  output byte_t      rx_byte,
  output logic       done
);

  shift_cmd_e cur_cmd;
  logic [8:0] slot;  // one-hot, slot 8 is the ack bit
  byte_t      sh_out;
  byte_t      sh_in;
  logic       one_bit;
  logic       last_slot;
  logic       end_of_bit;

  assign one_bit    = (cur_cmd == cmd_start) || (cur_cmd == cmd_stop);
  assign last_slot  = one_bit || slot[8];
  assign end_of_bit = tick && (phase == ph_fall);
  assign done       = end_of_bit && last_slot && (cur_cmd != cmd_none);
  assign rx_byte    = sh_in;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cur_cmd <= cmd_none;
      slot    <= '0;
      sda_out <= 1'b1;
      sda_en  <= 1'b0;
    end else if (load) begin
      cur_cmd <= cmd;
      slot    <= 9'd1;
      // level for the first slot, set early in phase 0
      case (cmd)
        cmd_start: begin
          sda_en  <= 1'b1;
          sda_out <= 1'b1;
        end
        cmd_stop: begin
          sda_en  <= 1'b1;
          sda_out <= 1'b0;
        end
        cmd_send: begin
          sda_en  <= 1'b1;
          sda_out <= tx_byte[7];  // msb first
        end
        cmd_recv: begin
          sda_en  <= 1'b0;
        end
        default: begin
          sda_en  <= sda_en;
        end
      endcase
    end else if (cur_cmd != cmd_none) begin
      // start falls and stop rises while scl is high
      if (tick && (phase == ph_rise) && one_bit) begin
        sda_out <= (cur_cmd == cmd_stop);
      end
      if (end_of_bit) begin
        if (last_slot) begin
          cur_cmd <= cmd_none;
          slot    <= '0;
          if (cur_cmd == cmd_stop) begin
            sda_en <= 1'b0;  // bus free
          end
        end else begin
          slot <= slot << 1;
          if (slot[7]) begin
            // ack slot: released on send, nack on recv
            sda_en  <= (cur_cmd == cmd_recv);
            sda_out <= 1'b1;
          end else if (cur_cmd == cmd_send) begin
            sda_out <= sh_out[6];
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      sh_out <= tx_byte;
    end else if (end_of_bit && (cur_cmd == cmd_send)) begin
      sh_out <= sh_out << 1;
    end
    if (tick && (phase == ph_high) && (cur_cmd == cmd_recv) && !slot[8]) begin
      sh_in <= {sh_in[6:0], sda_in};  // sampled at end of scl high
    end
  end

endmodule

/* rtl/eeprom_main_fsm.sv */
module eeprom_main_fsm import eeprom_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       wr,
  input  logic       rd,
  input  addr_t      addr,
  input  byte_t      data_in,
  input  logic       done,
  input  byte_t      rx_byte,
  output logic       run,
  output shift_cmd_e cmd,
  output logic       load,
  output byte_t      tx_byte,
  output byte_t      data_out,
  output logic       ack
);

  typedef enum logic [3:0] {
    st_idle,
    st_start,
    st_ctrl_wr,
    st_addr_wr,
    st_data_wr,
    st_restart,
    st_ctrl_rd,
    st_data_rd,
    st_stop,
    st_ackn
  } state_e;

  state_e state;
  state_e state_nxt;
  logic   is_read;
  logic   take;
  addr_t  addr_q;
  byte_t  data_q;

  // only an idle controller accepts a strobe
  assign take = (state == st_idle) && (wr || rd);
  assign ack  = (state == st_ackn);  // one cycle after the stop's done

  // sequence of the shifter steps
  always_comb begin
    case (state)
      st_start:   state_nxt = st_ctrl_wr;
      st_ctrl_wr: state_nxt = st_addr_wr;
      st_addr_wr: state_nxt = is_read ? st_restart : st_data_wr;
      st_data_wr: state_nxt = st_stop;
      st_restart: state_nxt = st_ctrl_rd;
      st_ctrl_rd: state_nxt = st_data_rd;
      st_data_rd: state_nxt = st_stop;
      st_stop:    state_nxt = st_ackn;
      default:    state_nxt = st_idle;
    endcase
  end

  // shifter command for the current step
  always_comb begin
    case (state)
      st_start,
      st_restart: cmd = cmd_start;
      st_ctrl_wr,
      st_addr_wr,
      st_data_wr,
      st_ctrl_rd: cmd = cmd_send;
      st_data_rd: cmd = cmd_recv;
      st_stop:    cmd = cmd_stop;
      default:    cmd = cmd_none;
    endcase
  end

  always_comb begin
    case (state)
      st_ctrl_wr: tx_byte = {ctrl_code, addr_q[10:8], 1'b0};  // write flag
      st_addr_wr: tx_byte = addr_q[7:0];
      st_data_wr: tx_byte = data_q;
      st_ctrl_rd: tx_byte = {ctrl_code, addr_q[10:8], 1'b1};  // read flag
      default:    tx_byte = '0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= st_idle;
      is_read  <= 1'b0;
      run      <= 1'b0;
      load     <= 1'b0;
      data_out <= '0;
    end else begin
      load <= 1'b0;
      case (state)
        st_idle: begin
          if (take) begin
            is_read <= !wr;  // wr wins over rd
            run     <= 1'b1;
            load    <= 1'b1;
            state   <= st_start;
          end
        end
        st_ackn: begin
          state <= st_idle;
        end
        default: begin
          if (done) begin
            state <= state_nxt;
            if (state == st_data_rd) begin
              data_out <= rx_byte;
            end
            if (state == st_stop) begin
              run <= 1'b0;
            end else begin
              load <= 1'b1;
            end
          end
        end
      endcase
    end
  end

  // command latched at the accepted strobe
  always_ff @(posedge clk) begin
    if (take) begin
      addr_q <= addr;
      data_q <= data_in;
    end
  end

endmodule

/* rtl/eeprom_wr.sv */
module eeprom_wr import eeprom_pkg::*; #(
  parameter int clk_div = 4  // clk cycles per quarter bit
) (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  wr,
  input  logic  rd,
  input  addr_t addr,
  input  byte_t data_in,
  output byte_t data_out,
  output logic  ack,
  output logic  scl,
  input  logic  sda_in,
  output logic  sda_out,
  output logic  sda_en
);

  logic       run;
  logic       tick;
  bit_phase_t phase;
  shift_cmd_e cmd;
  logic       load;
  logic       done;
  byte_t      tx_byte;
  byte_t      rx_byte;

  eeprom_main_fsm eeprom_main_fsm_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr       (wr),
    .rd       (rd),
    .addr     (addr),
    .data_in  (data_in),
    .done     (done),
    .rx_byte  (rx_byte),
    .run      (run),
    .cmd      (cmd),
    .load     (load),
    .tx_byte  (tx_byte),
    .data_out (data_out),
    .ack      (ack)
  );

  scl_timer #(
    .clk_div (clk_div)
  ) scl_timer_i (
    .clk   (clk),
    .rst_n (rst_n),
    .run   (run),
    .tick  (tick),
    .phase (phase),
    .scl   (scl)
  );

  sda_shifter sda_shifter_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .cmd     (cmd),
    .load    (load),
    .tx_byte (tx_byte),
    .tick    (tick),
    .phase   (phase),
    .sda_in  (sda_in),
    .sda_out (sda_out),
    .sda_en  (sda_en),
    .rx_byte (rx_byte),
    .done    (done)
  );

endmodule

/* test/eeprom_slave_model.sv */
module eeprom_slave_model (
  input  logic scl,
  input  logic sda,
  output logic sda_low,
  output logic bad_ctrl
);
  timeunit 1ns;
  timeprecision 1ps;

  typedef enum logic [2:0] {sl_idle, sl_ctrl, sl_addr, sl_wdata, sl_rdata} slave_state_e;

  logic [7:0]   mem [0:2047];
  slave_state_e state     = sl_idle;
  logic [10:0]  ptr       = '0;
  logic [7:0]   sh        = '0;
  logic [7:0]   rd_byte   = '0;
  int           cnt       = 0;
  int           rcnt      = 0;  // data bits handed to the master
  logic         ack_due   = 1'b0;
  logic         ack_on    = 1'b0;
  logic         drive_nxt = 1'b0;

  initial begin
    sda_low  = 1'b0;
    bad_ctrl = 1'b0;
    for (int i = 0; i < 2048; i++) begin
      mem[i] = 8'hff;  // erased part
    end
  end

  task automatic take_byte();
    case (state)
      sl_ctrl: begin
        if (sh[7:4] != 4'b1010) begin
          $display("eeprom model: control byte %02h does not carry device code 1010", sh);
          bad_ctrl = 1'b1;
        end
        ptr[10:8] = sh[3:1];  // block select
        if (sh[0]) begin
          rd_byte = mem[ptr];
          rcnt    = 0;
          state   = sl_rdata;
        end else begin
          state = sl_addr;
        end
      end
      sl_addr: begin
        ptr[7:0] = sh;
        state    = sl_wdata;
      end
      sl_wdata: begin
        mem[ptr] = sh;
        state    = sl_idle;
      end
      default: ;
    endcase
    ack_due = 1'b1;
  endtask

  // start or repeated start
  always @(negedge sda) begin
    if (scl === 1'b1) begin
      state   = sl_ctrl;
      cnt     = 0;
      ack_due = 1'b0;
      ack_on  = 1'b0;
    end
  end

  // stop
  always @(posedge sda) begin
    if (scl === 1'b1) begin
      state   = sl_idle;
      ack_due = 1'b0;
      ack_on  = 1'b0;
    end
  end

  always @(posedge scl) begin
    if (!ack_on) begin
      case (state)
        sl_ctrl, sl_addr, sl_wdata: begin
          sh  = {sh[6:0], sda};
          cnt = cnt + 1;
          if (cnt == 8) begin
            cnt = 0;
            take_byte();
          end
        end
        sl_rdata: begin
          if (rcnt < 8) begin
            rcnt = rcnt + 1;
          end else begin
            state = sl_idle;  // master nack ends the read
          end
        end
        default: ;
      endcase
    end
  end

  // data and ack change a little after scl falls
  always @(negedge scl) begin
    if (ack_on) begin
      ack_on    = 1'b0;
      drive_nxt = (state == sl_rdata) && !rd_byte[7];
    end else if (ack_due) begin
      ack_due   = 1'b0;
      ack_on    = 1'b1;
      drive_nxt = 1'b1;
    end else if (state == sl_rdata && rcnt < 8) begin
      drive_nxt = !rd_byte[7 - rcnt];
    end else begin
      drive_nxt = 1'b0;
    end
    #2;
    sda_low = drive_nxt;
  end

endmodule

/* test/eeprom_wr_tb.sv */
module eeprom_wr_tb import eeprom_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int clk_div   = 4;
  localparam int clk_ns    = 20;
  localparam int read_bits = 39;
  localparam int ack_limit = read_bits * 4 * clk_div + 40;  // cycles

  logic  clk = 1'b0;
  logic  rst_n;
  logic  wr;
  logic  rd;
  logic  ack;
  logic  scl;
  logic  sda_in;
  logic  sda_out;
  logic  sda_en;
  logic  sda_low;
  logic  bad_ctrl;
  addr_t addr;
  byte_t data_in;
  byte_t data_out;
  int    seed = 44641;
  int    accepted = 0;
  int    acks = 0;
  logic  ack_prev = 1'b0;
  logic  cases_ready = 1'b0;
  logic [7:0] case_op [$];
  addr_t case_addr [$];
  byte_t case_data [$];
  byte_t case_exp [$];

  always #(clk_ns / 2) clk = !clk;

  eeprom_wr #(.clk_div(clk_div)) eeprom_wr_i (
    .clk(clk), .rst_n(rst_n), .wr(wr), .rd(rd), .addr(addr), .data_in(data_in),
    .data_out(data_out), .ack(ack), .scl(scl), .sda_in(sda_in), .sda_out(sda_out),
    .sda_en(sda_en)
  );

  // wired-and with pull-up
  assign sda_in = !((sda_en && !sda_out) || sda_low);

  eeprom_slave_model eeprom_slave_model_i (
    .scl(scl), .sda(sda_in), .sda_low(sda_low), .bad_ctrl(bad_ctrl)
  );

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1, "run aborted");
  endtask

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("ERR %0d ns %s: got %0h, expected %0h", $time, what, got, exp));
    end
  endtask

  task automatic load_cases();
    int    fd;
    int    n;
    string line;
    addr_t a;
    byte_t d;
    byte_t e;
    fd = $fopen("test/eeprom_cases.txt", "r");
    if (fd == 0) abort_run("cannot open test/eeprom_cases.txt");
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (line.len() > 2 && line.getc(0) != "#") begin
        n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h", a, d, e);
        if (n != 3 || (line.getc(0) != "W" && line.getc(0) != "R")) begin
          abort_run({"malformed line in case file: ", line});
        end
        case_op.push_back(line.getc(0));
        case_addr.push_back(a);
        case_data.push_back(d);
        case_exp.push_back(e);
      end
    end
    $fclose(fd);
  endtask

  task automatic issue_cmd(input logic is_wr, input addr_t a, input byte_t d);
    @(posedge clk);
    #2;
    wr      = is_wr;
    rd      = !is_wr;
    addr    = a;
    data_in = d;
    accepted++;
    @(posedge clk);
    #2;
    wr = 1'b0;
    rd = 1'b0;
  endtask

  // busy_at puts a stray wr strobe that many cycles into the transaction
  task automatic wait_ack(input int busy_at, input addr_t busy_addr, input byte_t busy_data);
    int   n;
    logic seen;
    n    = 0;
    seen = 1'b0;
    while (!seen && n < ack_limit) begin
      @(negedge clk);
      if (ack) begin
        seen = 1'b1;
      end else begin
        @(posedge clk);
        #2;
        n++;
        wr = (n == busy_at);
        if (n == busy_at) begin
          addr    = busy_addr;
          data_in = busy_data;
        end
      end
    end
    if (!seen) abort_run($sformatf("no ack within %0d cycles of the command", ack_limit));
  endtask

  always @(negedge clk) begin
    if (rst_n && ack) begin
      if (ack_prev) abort_run("ack stayed high for more than one cycle");
      else if (acks >= accepted) abort_run("ack came without an accepted command");
      else acks++;
    end
    ack_prev = ack;
  end

  always @(posedge bad_ctrl) abort_run("serial EEPROM model saw a bad control byte");

  initial begin
    longint limit;
    wait (cases_ready);
    limit = longint'(case_op.size()) * read_bits * 4 * clk_div * clk_ns + 50000;
    #(limit);
    abort_run($sformatf("run timed out, no result after %0d ns", limit));
  end

  initial begin
    byte_t last_rd;
    int    busy_at;
    logic  is_wr;
    rst_n   = 1'b0;
    wr      = 1'b0;
    rd      = 1'b0;
    addr    = '0;
    data_in = '0;
    last_rd = '0;
    load_cases();
    cases_ready = 1'b1;
    repeat (10) @(posedge clk);
    #2;
    check_eq(ack, 0, "ack in reset");
    check_eq(sda_en, 0, "sda_en in reset");
    check_eq(scl, 1, "scl in reset");
    rst_n = 1'b1;
    repeat (5) begin
      @(negedge clk);
      check_eq({ack, sda_en, scl}, 3'b001, "idle bus after reset");
      check_eq(data_out, 0, "data_out after reset");
    end
    for (int i = 0; i < case_op.size(); i++) begin
      is_wr   = (case_op[i] == "W");
      busy_at = 8 + int'($unsigned($random(seed)) % 32'd400);
      issue_cmd(is_wr, case_addr[i], case_data[i]);
      wait_ack(busy_at, case_addr[i], is_wr ? ~case_data[i] : ~case_exp[i]);
      if (is_wr) begin
        check_eq(data_out, last_rd, "data_out held over a write");
      end else begin
        check_eq(data_out, case_exp[i], $sformatf("read of address %03h", case_addr[i]));
        last_rd = case_exp[i];
      end
    end
    repeat (100) @(negedge clk);  // no late ack
    $display("TESTS PASSED");
    $finish;
  end

endmodule

/* build.f */
rtl/eeprom_pkg.sv
rtl/scl_timer.sv
rtl/sda_shifter.sv
rtl/eeprom_main_fsm.sv
rtl/eeprom_wr.sv
test/eeprom_slave_model.sv
test/eeprom_wr_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
  --top-module eeprom_wr_tb -f build.f

# keep the output of a failing run for the search below
out=$(./obj_dir/Veeprom_wr_tb 2>&1) || true
echo "$out"

if grep -qx "TESTS PASSED" <<< "$out"; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi

/* test/eeprom_cases.txt */
# op addr data expect, all hex; W = byte write, R = random read
# data is unused for R, expect is unused for W
R 000 00 ff
W 000 3c 00
R 000 00 3c
W 123 a5 00
W 124 5a 00
W 7ff 81 00
R 123 00 a5
R 7ff 00 81
W 123 c3 00
R 123 00 c3
R 124 00 5a
W 4b0 e7 00
R 4b0 00 e7
R 2aa 00 ff
R 000 00 3c
